//--- hw/sya_defines.svh
`ifndef SYA_DEFINES_SVH
`define SYA_DEFINES_SVH

// =========================================================================
// Array geometry
// =========================================================================
`define SYA_NUM_ROW 4
`define SYA_NUM_COL 4

// =========================================================================
// Datapath and counter widths
// =========================================================================
// Activation, weight and output element
`define SYA_ACT_W 8
// Accumulator wide enough for long channel runs
`define SYA_PSUM_W 32
// Global buffer address
`define SYA_ADDR_W 16
// Channel and group counts
`define SYA_CNT_W 16

`endif

//--- hw/sya_pkg.sv
`include "sya_defines.svh"

package sya_pkg;

    // Scalars
    typedef logic signed [`SYA_ACT_W-1:0]  act_t;
    typedef logic signed [`SYA_PSUM_W-1:0] psum_t;
    typedef logic [`SYA_ADDR_W-1:0]        addr_t;
    typedef logic [`SYA_CNT_W-1:0]         cnt_t;

    // One operand per array edge lane
    typedef act_t [`SYA_NUM_ROW-1:0] act_row_t;
    typedef act_t [`SYA_NUM_COL-1:0] wgt_col_t;

    // Requantized row of unsigned bytes
    typedef logic [`SYA_NUM_COL-1:0][`SYA_ACT_W-1:0] ofm_row_t;

    typedef psum_t [`SYA_NUM_ROW-1:0][`SYA_NUM_COL-1:0] psum_grid_t;

    // 93-bit configuration word with fields listed from the MSB
    typedef struct packed {
        addr_t                 ofm_base;
        addr_t                 act_base;
        addr_t                 wgt_base;
        cnt_t                  num_grp;
        cnt_t                  chn;
        logic [4:0]            shift;
        logic [`SYA_ACT_W-1:0] zp;
    } sya_cfg_t;

    typedef enum logic [1:0] {IDLE, READ, FLUSH, DRAIN} sya_state_e;

endpackage

//--- hw/sya_ctrl.sv
`timescale 1ns/1ps
`include "sya_defines.svh"

module sya_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_vld,
    output logic                cfg_rdy,
    input  sya_pkg::sya_cfg_t   cfg_info,
    output sya_pkg::addr_t      act_addr,
    output logic                act_addr_vld,
    input  logic                act_addr_rdy,
    output sya_pkg::addr_t      wgt_addr,
    output logic                wgt_addr_vld,
    input  logic                wgt_addr_rdy,
    input  logic                act_dat_vld,
    input  logic                wgt_dat_vld,
    output logic                dat_rdy,
    output logic                step,
    output logic                zero_in,
    output logic                acc_clr,
    output logic                drain_go,
    input  logic                drain_done,
    output sya_pkg::sya_cfg_t   cfg
);

    import sya_pkg::*;

    // Zero steps needed to push the last channel through PE (R-1,C-1)
    localparam int FLUSH_STEPS = `SYA_NUM_ROW + `SYA_NUM_COL - 1;
    localparam int FLUSH_W     = $clog2(FLUSH_STEPS + 1);

    sya_state_e           state;
    cnt_t                 addr_ch;
    cnt_t                 dat_ch;
    cnt_t                 grp_idx;
    addr_t                grp_base;
    logic [FLUSH_W-1:0]   flush_cnt;

    logic addr_fire;
    logic dat_fire;
    logic dat_last;
    logic flush_last;
    logic grp_last;

    // =========================================================================
    // Read address and data handshakes
    // =========================================================================
    // Each address valid waits for the other channel's ready
    assign act_addr_vld = (state == READ) && (addr_ch < cfg.chn) && wgt_addr_rdy;
    assign wgt_addr_vld = (state == READ) && (addr_ch < cfg.chn) && act_addr_rdy;
    assign addr_fire    = act_addr_vld && act_addr_rdy;

    assign act_addr = cfg.act_base + grp_base + addr_ch;
    assign wgt_addr = cfg.wgt_base + addr_ch;

    assign dat_rdy  = (state == READ) && (dat_ch < cfg.chn);
    assign dat_fire = dat_rdy && act_dat_vld && wgt_dat_vld;

    assign dat_last   = dat_ch == cfg.chn - cnt_t'(1);
    assign flush_last = flush_cnt == FLUSH_W'(FLUSH_STEPS - 1);
    assign grp_last   = grp_idx == cfg.num_grp - cnt_t'(1);

    assign cfg_rdy  = state == IDLE;
    assign zero_in  = state == FLUSH;
    // Flush steps ignore back-pressure
    assign step     = dat_fire || (state == FLUSH);
    assign drain_go = state == DRAIN;
    // Accumulators clear on the edge that takes the last row
    assign acc_clr  = drain_done;

    // =========================================================================
    // Group / channel sequencer
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            cfg       <= '0;
            addr_ch   <= '0;
            dat_ch    <= '0;
            grp_idx   <= '0;
            grp_base  <= '0;
            flush_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cfg_vld) begin
                        cfg      <= cfg_info;
                        addr_ch  <= '0;
                        dat_ch   <= '0;
                        grp_idx  <= '0;
                        grp_base <= '0;
                        state    <= READ;
                    end
                end
                READ: begin
                    if (addr_fire) begin
                        addr_ch <= addr_ch + cnt_t'(1);
                    end
                    if (dat_fire) begin
                        dat_ch <= dat_ch + cnt_t'(1);
                        if (dat_last) begin
                            flush_cnt <= '0;
                            state     <= FLUSH;
                        end
                    end
                end
                FLUSH: begin
                    flush_cnt <= flush_cnt + FLUSH_W'(1);
                    if (flush_last) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (drain_done) begin
                        addr_ch <= '0;
                        dat_ch  <= '0;
                        if (grp_last) begin
                            state <= IDLE;
                        end else begin
                            // Next group reads the following chn activations
                            grp_idx  <= grp_idx + cnt_t'(1);
                            grp_base <= grp_base + cfg.chn;
                            state    <= READ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hw/sya_skew.sv
`timescale 1ns/1ps
`include "sya_defines.svh"

module sya_skew #(
    parameter type lane_t = sya_pkg::act_row_t
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   step,
    input  logic   zero_in,
    input  lane_t  din,
    output lane_t  dout
);

    import sya_pkg::*;

    localparam int NUM_LANE = $bits(lane_t) / `SYA_ACT_W;

    // Lane k runs k step positions behind lane 0
    for (genvar k = 0; k < NUM_LANE; k++) begin : g_lane
        if (k == 0) begin : g_direct
            assign dout[k] = zero_in ? '0 : din[k];
        end else begin : g_chain
            act_t stage [k];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int j = 0; j < k; j++) begin
                        stage[j] <= '0;
                    end
                end else if (step) begin
                    stage[0] <= zero_in ? '0 : din[k];
                    for (int j = 1; j < k; j++) begin
                        stage[j] <= stage[j-1];
                    end
                end
            end

            assign dout[k] = stage[k-1];
        end
    end

endmodule

//--- hw/sya_pe_array.sv
`timescale 1ns/1ps
`include "sya_defines.svh"

module sya_pe_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  step,
    input  logic                  acc_clr,
    input  sya_pkg::act_row_t     act_w,
    input  sya_pkg::wgt_col_t     wgt_n,
    output sya_pkg::psum_grid_t   psum
);

    import sya_pkg::*;

    localparam int NUM_ROW = `SYA_NUM_ROW;
    localparam int NUM_COL = `SYA_NUM_COL;

    // Operands seen by each PE and the copies it passes on
    act_t  act_in  [NUM_ROW][NUM_COL];
    act_t  wgt_in  [NUM_ROW][NUM_COL];
    act_t  act_fwd [NUM_ROW][NUM_COL];
    act_t  wgt_fwd [NUM_ROW][NUM_COL];
    psum_t acc     [NUM_ROW][NUM_COL];

    for (genvar r = 0; r < NUM_ROW; r++) begin : g_row
        for (genvar c = 0; c < NUM_COL; c++) begin : g_col

            // West edge from the skew, else from the neighbour
            if (c == 0) begin : g_west_edge
                assign act_in[r][c] = act_w[r];
            end else begin : g_west_pe
                assign act_in[r][c] = act_fwd[r][c-1];
            end

            if (r == 0) begin : g_north_edge
                assign wgt_in[r][c] = wgt_n[c];
            end else begin : g_north_pe
                assign wgt_in[r][c] = wgt_fwd[r-1][c];
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    acc[r][c]     <= '0;
                    act_fwd[r][c] <= '0;
                    wgt_fwd[r][c] <= '0;
                end else if (acc_clr) begin
                    acc[r][c]     <= '0;
                    act_fwd[r][c] <= '0;
                    wgt_fwd[r][c] <= '0;
                end else if (step) begin
                    acc[r][c]     <= acc[r][c]
                                   + psum_t'(act_in[r][c]) * psum_t'(wgt_in[r][c]);
                    act_fwd[r][c] <= act_in[r][c];
                    wgt_fwd[r][c] <= wgt_in[r][c];
                end
            end

            assign psum[r][c] = acc[r][c];
        end
    end

endmodule

//--- hw/sya_drain.sv
`timescale 1ns/1ps
`include "sya_defines.svh"

module sya_drain (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  drain_go,
    input  sya_pkg::psum_grid_t   psum,
    input  sya_pkg::sya_cfg_t     cfg,
    output sya_pkg::ofm_row_t     ofm_dat,
    output sya_pkg::addr_t        ofm_addr,
    output logic                  ofm_vld,
    input  logic                  ofm_rdy,
    output logic                  drain_done
);

    import sya_pkg::*;

    localparam int NUM_ROW = `SYA_NUM_ROW;
    localparam int NUM_COL = `SYA_NUM_COL;
    localparam int ROW_W   = $clog2(NUM_ROW);

    logic [ROW_W-1:0] row_idx;
    cnt_t             grp_cnt;
    addr_t            wr_off;
    logic             wr_fire;
    logic             row_last;

    // ReLU, then shift, then zero point, mod 256
    function automatic logic [`SYA_ACT_W-1:0] requant(
        input psum_t                 p,
        input logic [4:0]            sh,
        input logic [`SYA_ACT_W-1:0] zp
    );
        psum_t shifted;
        shifted = p >>> sh;
        if (p < 0) begin
            return '0;
        end
        return shifted[`SYA_ACT_W-1:0] + zp;
    endfunction

    // =========================================================================
    // Row select and write handshake
    // =========================================================================
    // Ctrl drops drain_go right after the last row, so nothing is left pending
    assign ofm_vld    = drain_go;
    assign wr_fire    = ofm_vld && ofm_rdy;
    assign row_last   = row_idx == ROW_W'(NUM_ROW - 1);
    assign drain_done = wr_fire && row_last;
    assign ofm_addr   = cfg.ofm_base + wr_off;

    always_comb begin
        for (int c = 0; c < NUM_COL; c++) begin
            ofm_dat[c] = requant(psum[row_idx][c], cfg.shift, cfg.zp);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_idx <= '0;
            grp_cnt <= '0;
            wr_off  <= '0;
        end else if (wr_fire) begin
            row_idx <= row_last ? '0 : row_idx + ROW_W'(1);
            if (row_last && grp_cnt == cfg.num_grp - cnt_t'(1)) begin
                // Next run starts again at its own base
                grp_cnt <= '0;
                wr_off  <= '0;
            end else begin
                if (row_last) begin
                    grp_cnt <= grp_cnt + cnt_t'(1);
                end
                wr_off <= wr_off + addr_t'(1);
            end
        end
    end

endmodule

//--- hw/sya_top.sv
`timescale 1ns/1ps

module sya_top (
    input  logic                clk,
    input  logic                rst_n,
    // Configuration
    input  logic                cfg_vld,
    output logic                cfg_rdy,
    input  sya_pkg::sya_cfg_t   cfg_info,
    // Read addresses
    output sya_pkg::addr_t      act_addr,
    output logic                act_addr_vld,
    input  logic                act_addr_rdy,
    output sya_pkg::addr_t      wgt_addr,
    output logic                wgt_addr_vld,
    input  logic                wgt_addr_rdy,
    // Read data
    input  sya_pkg::act_row_t   act_dat,
    input  logic                act_dat_vld,
    output logic                act_dat_rdy,
    input  sya_pkg::wgt_col_t   wgt_dat,
    input  logic                wgt_dat_vld,
    output logic                wgt_dat_rdy,
    // Output writes
    output sya_pkg::ofm_row_t   ofm_dat,
    output sya_pkg::addr_t      ofm_addr,
    output logic                ofm_vld,
    input  logic                ofm_rdy
);

    import sya_pkg::*;

    sya_cfg_t   cfg;
    act_row_t   act_w;
    wgt_col_t   wgt_n;
    psum_grid_t psum;
    logic       step;
    logic       zero_in;
    logic       acc_clr;
    logic       drain_go;
    logic       drain_done;

    // Both data channels share one ready
    assign wgt_dat_rdy = act_dat_rdy;

    sya_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld      (cfg_vld),
        .cfg_rdy      (cfg_rdy),
        .cfg_info     (cfg_info),
        .act_addr     (act_addr),
        .act_addr_vld (act_addr_vld),
        .act_addr_rdy (act_addr_rdy),
        .wgt_addr     (wgt_addr),
        .wgt_addr_vld (wgt_addr_vld),
        .wgt_addr_rdy (wgt_addr_rdy),
        .act_dat_vld  (act_dat_vld),
        .wgt_dat_vld  (wgt_dat_vld),
        .dat_rdy      (act_dat_rdy),
        .step         (step),
        .zero_in      (zero_in),
        .acc_clr      (acc_clr),
        .drain_go     (drain_go),
        .drain_done   (drain_done),
        .cfg          (cfg)
    );

    sya_skew #(.lane_t(act_row_t)) i_act_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .zero_in (zero_in),
        .din     (act_dat),
        .dout    (act_w)
    );

    sya_skew #(.lane_t(wgt_col_t)) i_wgt_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .zero_in (zero_in),
        .din     (wgt_dat),
        .dout    (wgt_n)
    );

    sya_pe_array i_pe_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .acc_clr (acc_clr),
        .act_w   (act_w),
        .wgt_n   (wgt_n),
        .psum    (psum)
    );

    sya_drain i_drain (
        .clk        (clk),
        .rst_n      (rst_n),
        .drain_go   (drain_go),
        .psum       (psum),
        .cfg        (cfg),
        .ofm_dat    (ofm_dat),
        .ofm_addr   (ofm_addr),
        .ofm_vld    (ofm_vld),
        .ofm_rdy    (ofm_rdy),
        .drain_done (drain_done)
    );

endmodule

//--- tb/sya_assertions.sv
`timescale 1ns/1ps

module sya_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                cfg_rdy,
    input logic                act_addr_vld,
    input logic                act_addr_rdy,
    input logic                wgt_addr_vld,
    input logic                wgt_addr_rdy,
    input logic                ofm_vld,
    input logic                ofm_rdy,
    input sya_pkg::ofm_row_t   ofm_dat,
    input sya_pkg::addr_t      ofm_addr
);

    int fail_cnt = 0;

    // A stalled write keeps its row and address
    a_ofm_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_vld && !ofm_rdy |=> ofm_vld && $stable(ofm_dat) && $stable(ofm_addr))
        else begin
            fail_cnt++;
            $error("ofm beat dropped or changed under back-pressure");
        end

    // Both address channels transfer in the same cycle
    a_addr_pair: assert property (@(posedge clk) disable iff (!rst_n)
        act_addr_vld && act_addr_rdy |-> wgt_addr_vld && wgt_addr_rdy)
        else begin
            fail_cnt++;
            $error("activation address beat without weight address beat");
        end

    a_idle_addr: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_rdy |-> !act_addr_vld && !wgt_addr_vld)
        else begin
            fail_cnt++;
            $error("read address valid while idle");
        end

    a_idle_ofm: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_rdy |-> !ofm_vld)
        else begin
            fail_cnt++;
            $error("ofm_vld while idle");
        end

endmodule

bind sya_top sya_assertions i_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_rdy      (cfg_rdy),
    .act_addr_vld (act_addr_vld),
    .act_addr_rdy (act_addr_rdy),
    .wgt_addr_vld (wgt_addr_vld),
    .wgt_addr_rdy (wgt_addr_rdy),
    .ofm_vld      (ofm_vld),
    .ofm_rdy      (ofm_rdy),
    .ofm_dat      (ofm_dat),
    .ofm_addr     (ofm_addr)
);

//--- tb/sya_tb.sv
`timescale 1ns/1ps
`include "sya_defines.svh"

module sya_tb;

    import sya_pkg::*;

    localparam int NUM_ROW   = `SYA_NUM_ROW;
    localparam int NUM_COL   = `SYA_NUM_COL;
    localparam int FLUSH     = NUM_ROW + NUM_COL - 1;
    localparam int MEM_DEPTH = 1024;

    logic       clk;
    logic       rst_n;
    logic       cfg_vld;
    logic       cfg_rdy;
    sya_cfg_t   cfg_info;
    addr_t      act_addr;
    logic       act_addr_vld;
    logic       act_addr_rdy;
    addr_t      wgt_addr;
    logic       wgt_addr_vld;
    logic       wgt_addr_rdy;
    act_row_t   act_dat;
    logic       act_dat_vld;
    logic       act_dat_rdy;
    wgt_col_t   wgt_dat;
    logic       wgt_dat_vld;
    logic       wgt_dat_rdy;
    ofm_row_t   ofm_dat;
    addr_t      ofm_addr;
    logic       ofm_vld;
    logic       ofm_rdy;

    // Buffer contents, reads in flight and expected traffic
    act_row_t   act_mem [MEM_DEPTH];
    wgt_col_t   wgt_mem [MEM_DEPTH];
    addr_t      act_rd_q [$];
    addr_t      wgt_rd_q [$];
    int         due_q [$];
    addr_t      exp_act_q [$];
    addr_t      exp_wgt_q [$];
    ofm_row_t   exp_ofm_q [$];
    addr_t      exp_oaddr_q [$];

    bit stress;
    int cyc = 0;
    int cyc_limit = 64;
    int err_cnt = 0;
    int check_cnt = 0;
    int test_cnt = 0;
    int test_fail_cnt = 0;

    sya_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > cyc_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cyc_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ========================================================================
    // Reference model and compare tasks
    // ========================================================================
    function automatic logic [9:0] mem_idx(input int a);
        return a[9:0];
    endfunction

    function automatic sya_cfg_t make_cfg(input int ofm_base, input int act_base,
                                          input int wgt_base, input int num_grp,
                                          input int chn, input int shift, input int zp);
        sya_cfg_t c;
        c.ofm_base = addr_t'(ofm_base);
        c.act_base = addr_t'(act_base);
        c.wgt_base = addr_t'(wgt_base);
        c.num_grp  = cnt_t'(num_grp);
        c.chn      = cnt_t'(chn);
        c.shift    = 5'(shift);
        c.zp       = 8'(zp);
        return c;
    endfunction

    // Expected row from channel sums with ReLU, shift and zero point
    function automatic ofm_row_t ref_row(input sya_cfg_t c, input int grp, input int row);
        ofm_row_t res;
        act_row_t a;
        wgt_col_t w;
        int       sum;
        for (int col = 0; col < NUM_COL; col++) begin
            sum = 0;
            for (int ch = 0; ch < int'(c.chn); ch++) begin
                a = act_mem[mem_idx(int'(c.act_base) + grp * int'(c.chn) + ch)];
                w = wgt_mem[mem_idx(int'(c.wgt_base) + ch)];
                sum += int'(a[row]) * int'(w[col]);
            end
            if (sum < 0) begin
                res[col] = 8'h00;
            end else begin
                res[col] = 8'((sum >> c.shift) + int'(c.zp));
            end
        end
        return res;
    endfunction

    // Generous bound per group that covers stressed reads
    function automatic int run_cycles(input sya_cfg_t c);
        return int'(c.num_grp) * (16 * int'(c.chn) + FLUSH + 8 * NUM_ROW + 8) + 16;
    endfunction

    task automatic check_ofm(input ofm_row_t got, input ofm_row_t exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t ns: %s got %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t ns: %s got %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t ns: %s got %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // ========================================================================
    // Buffer model and write monitor
    // ========================================================================
    initial begin : bus_model
        logic  addr_fire;
        logic  act_take;
        logic  wgt_take;
        logic  dat_fire;
        addr_t a_addr;
        addr_t w_addr;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            addr_fire = act_addr_vld && act_addr_rdy;
            act_take  = act_dat_vld && act_dat_rdy;
            wgt_take  = wgt_dat_vld && wgt_dat_rdy;
            dat_fire  = act_take && wgt_take;
            a_addr    = act_addr;
            w_addr    = wgt_addr;
            // Both data channels share one ready and move together
            if (act_take !== wgt_take) begin
                $display("Activation and weight data beats split at %0t ns", $time);
                err_cnt++;
            end
            if (addr_fire) begin
                if (exp_act_q.size() == 0) begin
                    $display("Unexpected read address beat at %0t ns", $time);
                    err_cnt++;
                end else begin
                    check_addr(a_addr, exp_act_q.pop_front(), "activation address");
                    check_addr(w_addr, exp_wgt_q.pop_front(), "weight address");
                end
            end
            @(posedge clk);
            #1;
            if (dat_fire) begin
                act_rd_q.delete(0);
                wgt_rd_q.delete(0);
                due_q.delete(0);
            end
            if (addr_fire) begin
                act_rd_q.push_back(a_addr);
                wgt_rd_q.push_back(w_addr);
                due_q.push_back(cyc + (stress ? int'($urandom_range(4, 0)) : 0));
            end
            // Head of the queue answers once its latency has passed
            if (act_rd_q.size() != 0 && due_q[0] <= cyc) begin
                act_dat     = act_mem[mem_idx(int'(act_rd_q[0]))];
                wgt_dat     = wgt_mem[mem_idx(int'(wgt_rd_q[0]))];
                act_dat_vld = 1'b1;
                wgt_dat_vld = 1'b1;
            end else begin
                act_dat_vld = 1'b0;
                wgt_dat_vld = 1'b0;
            end
            act_addr_rdy = stress ? ($urandom_range(3, 0) != 0) : 1'b1;
            wgt_addr_rdy = stress ? ($urandom_range(3, 0) != 0) : 1'b1;
            ofm_rdy      = stress ? ($urandom_range(2, 0) != 0) : 1'b1;
        end
    end

    initial begin : write_monitor
        forever begin
            @(negedge clk);
            if (rst_n && ofm_vld && ofm_rdy) begin
                if (exp_ofm_q.size() == 0) begin
                    $display("Unexpected output write at %0t ns to %h", $time, ofm_addr);
                    err_cnt++;
                end else begin
                    check_ofm(ofm_dat, exp_ofm_q.pop_front(), "output row");
                    check_addr(ofm_addr, exp_oaddr_q.pop_front(), "output address");
                end
            end
        end
    end

    // ========================================================================
    // Run control
    // ========================================================================
    task automatic start_cfg(input sya_cfg_t c);
        int own;
        own = int'(c.num_grp) * NUM_ROW;
        for (int g = 0; g < int'(c.num_grp); g++) begin
            for (int ch = 0; ch < int'(c.chn); ch++) begin
                exp_act_q.push_back(addr_t'(int'(c.act_base) + g * int'(c.chn) + ch));
                exp_wgt_q.push_back(addr_t'(int'(c.wgt_base) + ch));
            end
            for (int r = 0; r < NUM_ROW; r++) begin
                exp_ofm_q.push_back(ref_row(c, g, r));
                exp_oaddr_q.push_back(addr_t'(int'(c.ofm_base) + g * NUM_ROW + r));
            end
        end
        cyc_limit += run_cycles(c);
        @(posedge clk);
        #1;
        cfg_info = c;
        cfg_vld  = 1'b1;
        do begin
            @(negedge clk);
        end while (!cfg_rdy);
        // Earlier writes must all have landed before a new run is taken
        if (exp_ofm_q.size() != own) begin
            $display("Configuration taken with %0d earlier writes outstanding",
                     exp_ofm_q.size() - own);
            err_cnt++;
        end
        @(posedge clk);
        #1;
        cfg_vld = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (!cfg_rdy);
        if (exp_ofm_q.size() != 0 || exp_act_q.size() != 0) begin
            $display("Run ended with %0d writes and %0d reads missing",
                     exp_ofm_q.size(), exp_act_q.size());
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("Test %0d %s: ok", test_cnt, name);
        end else begin
            test_fail_cnt++;
            $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
        end
    endtask

    task automatic run_test(input string name, input sya_cfg_t c);
        int err_before;
        err_before = err_cnt;
        start_cfg(c);
        wait_idle();
        report_test(name, err_before);
    endtask

    initial begin : main
        int err_before;
        void'($urandom(58419));
        rst_n        = 1'b0;
        stress       = 1'b0;
        cfg_vld      = 1'b0;
        cfg_info     = '0;
        act_addr_rdy = 1'b0;
        wgt_addr_rdy = 1'b0;
        act_dat      = '0;
        act_dat_vld  = 1'b0;
        wgt_dat      = '0;
        wgt_dat_vld  = 1'b0;
        ofm_rdy      = 1'b0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            act_mem[i] = act_row_t'($urandom());
            wgt_mem[i] = wgt_col_t'($urandom());
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        err_before = err_cnt;
        @(negedge clk);
        check_flag(cfg_rdy, 1'b1, "cfg_rdy after reset");
        check_flag(act_addr_vld, 1'b0, "act_addr_vld after reset");
        check_flag(wgt_addr_vld, 1'b0, "wgt_addr_vld after reset");
        check_flag(act_dat_rdy, 1'b0, "data ready after reset");
        check_flag(wgt_dat_rdy, 1'b0, "weight data ready after reset");
        check_flag(ofm_vld, 1'b0, "ofm_vld after reset");
        start_cfg(make_cfg('h0300, 'h0010, 'h0100, 1, 1, 0, 0));
        wait_idle();
        report_test("reset state and single product", err_before);

        run_test("random data, 8 channels", make_cfg('h0310, 'h0020, 'h0110, 1, 8, 6, 3));
        run_test("read addresses, 3 groups", make_cfg('h0320, 'h0040, 'h0120, 3, 5, 7, 0));
        run_test("requantization", make_cfg('h0340, 'h0060, 'h0130, 2, 4, 10, 'hf0));

        stress = 1'b1;
        run_test("latency and back-pressure", make_cfg('h0400, 'h0200, 'h0140, 4, 6, 8, 'h11));

        err_before = err_cnt;
        start_cfg(make_cfg('h0500, 'h0080, 'h0180, 2, 3, 5, 'h40));
        start_cfg(make_cfg('h0600, 'h00c0, 'h01c0, 1, 7, 9, 'h07));
        wait_idle();
        report_test("back-to-back configurations", err_before);

        err_cnt += i_dut.i_assert.fail_cnt;
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/sya_pkg.sv
hw/sya_ctrl.sv
hw/sya_skew.sv
hw/sya_pe_array.sv
hw/sya_drain.sv
hw/sya_top.sv
tb/sya_assertions.sv
tb/sya_tb.sv

//--- Makefile
# Verilator flow for the systolic array testbench
TOP := sya_tb

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o sya_sim
	./obj_dir/sya_sim +verilator+error+limit+100 | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: lint sim clean
